// ==== build.f ====
src/i2cPkg.sv
src/cameraPkg.sv
src/i2cCmdIf.sv
src/i2cMasterEngine.sv
src/initScriptRom.sv
src/cameraInitSequencer.sv
src/camConfigTop.sv
verification/i2cSensorModel.sv
verification/camConfigChecker.sv
verification/camConfigTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the camera configuration testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module camConfigTb -f build.f -o camConfigSim

./obj_dir/camConfigSim | tee sim.log

if grep -q "Simulation failed" sim.log; then
   echo "run.sh: testbench reported failure"
   exit 1
fi
echo "run.sh: done"

// ==== verification/camConfigTb.sv ====
`default_nettype none

module camConfigTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int releaseTimeout = 20000;   // cycles
   localparam int quietCycles = 400;

   logic CLK_400K = 1'b0;
   logic RESET_N;
   wire i2cSda;
   logic i2cScl;
   logic [7:0] sensorId;
   logic cameraReleased;
   logic finalCheck;
   logic [1:0] wrongIds;
   int seed;
   int tbErrors;
   int checkErrors;
   int waitCnt;

   pullup (i2cSda);

   always #20 CLK_400K = ~CLK_400K;

   camConfigTop i_camConfigTop (
      .CLK_400K (CLK_400K),
      .RESET_N (RESET_N),
      .i2cScl (i2cScl),
      .i2cSda (i2cSda),
      .sensorId (sensorId),
      .cameraReleased (cameraReleased)
   );

   i2cSensorModel i_sensor (
      .sda (i2cSda),
      .scl (i2cScl),
      .wrongIds (wrongIds)
   );

   camConfigChecker i_checker (
      .CLK_400K (CLK_400K),
      .RESET_N (RESET_N),
      .scl (i2cScl),
      .sda (i2cSda),
      .cameraReleased (cameraReleased),
      .sensorId (sensorId),
      .wrongIds (wrongIds),
      .finalCheck (finalCheck),
      .errors (checkErrors)
   );

   task automatic expectValue(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         tbErrors++;
      end
   endtask

   initial begin
      RESET_N = 1'b0;
      finalCheck = 1'b0;
      tbErrors = 0;
      seed = 32'hb59;
      wrongIds = 2'($unsigned($random(seed)) % 4);
      $display("sensor answers %0d wrong IDs first", wrongIds);
      repeat (5) @(posedge CLK_400K);
      #1;
      expectValue("i2cScl", {7'd0, i2cScl}, 8'h01);
      expectValue("i2cSda", {7'd0, i2cSda}, 8'h01);   // released, pulled up
      expectValue("cameraReleased", {7'd0, cameraReleased}, 8'h00);
      expectValue("sensorId", sensorId, 8'h00);
      RESET_N = 1'b1;
      waitCnt = 0;
      while (!cameraReleased && waitCnt < releaseTimeout) begin
         @(posedge CLK_400K);
         #1;
         waitCnt++;
      end
      if (!cameraReleased) begin
         $display("timeout, cameraReleased did not rise within %0d cycles", releaseTimeout);
         tbErrors++;
      end else begin
         waitCnt = 0;
         while (waitCnt < quietCycles) begin   // checker flags any bus activity here
            @(posedge CLK_400K);
            #1;
            waitCnt++;
         end
      end
      finalCheck = 1'b1;
      @(posedge CLK_400K);
      #1;
      $display("errors: checker %0d, testbench %0d", checkErrors, tbErrors);
      if (checkErrors == 0 && tbErrors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/camConfigChecker.sv ====
`default_nettype none

module camConfigChecker (
   input wire logic CLK_400K,
   input wire logic RESET_N,
   input wire logic scl,
   input wire logic sda,
   input wire logic cameraReleased,
   input wire logic [7:0] sensorId,
   input wire logic [1:0] wrongIds,
   input wire logic finalCheck,
   output int errors
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int clkPeriod = 40;
   localparam int writeCount = 11;

   logic [7:0] frame [$];
   logic [7:0] curByte;
   logic inFrame = 1'b0;
   logic anyNack = 1'b0;
   logic ptrArmed = 1'b0;
   logic idMatched = 1'b0;
   logic released = 1'b0;
   int slot = 0;
   int nextEntry = 0;
   int writesSeen = 0;
   int badIds = 0;
   int nackedFrames = 0;
   int minGap = 0;
   time lastStop = 0;

   initial begin
      errors = 0;
   end

   // expected startup script as {addr, ptr, data}
   function automatic logic [31:0] scriptEntry(input int i);
      case (i)
         0: return {8'h6C, 16'h0103, 8'h01};
         1: return {8'hAA, 16'h0000, 8'd10};   // 0xAA marks a delay
         2: return {8'h6C, 16'h0100, 8'h00};
         3: return {8'h6C, 16'h0302, 8'h18};
         4: return {8'h6C, 16'h0303, 8'h00};
         5: return {8'h6C, 16'h0304, 8'h03};
         6: return {8'h6C, 16'h3018, 8'h72};
         7: return {8'h6C, 16'h3808, 8'h02};
         8: return {8'h6C, 16'h3809, 8'h80};
         9: return {8'h6C, 16'h380A, 8'h01};
         10: return {8'h6C, 16'h380B, 8'hE0};
         11: return {8'hAA, 16'h0000, 8'd10};
         12: return {8'h6C, 16'h0100, 8'h01};
         default: return 32'h0;
      endcase
   endfunction

   task automatic compareValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic reportError(input string what);
      $display("ERROR %s", what);
      errors++;
   endtask

   task automatic decodeFrame();
      logic [31:0] exp;
      if (anyNack) nackedFrames++;
      if (frame.size() == 2 && frame[0] == 8'h6D && !idMatched) begin
         if (!ptrArmed) reportError("ID read without an acknowledged pointer write");
         ptrArmed = 1'b0;
         if (!anyNack && frame[1] == 8'h88) idMatched = 1'b1;
         else if (!anyNack) badIds++;
      end else if (frame.size() == 3 && !idMatched) begin
         compareValue("slaveAddr", frame[0], 8'h6C);
         compareValue("regPtr", {frame[1], frame[2]}, 16'h300B);
         ptrArmed = !anyNack;
      end else if (frame.size() == 4 && idMatched && !anyNack) begin
         exp = scriptEntry(nextEntry);
         while (exp[31:24] == 8'hAA && nextEntry < 13) begin
            nextEntry++;
            exp = scriptEntry(nextEntry);
         end
         compareValue("slaveAddr", frame[0], exp[31:24]);
         compareValue("regPtr", {frame[1], frame[2]}, exp[23:8]);
         compareValue("wrData", frame[3], exp[7:0]);
         writesSeen++;
         nextEntry++;
         exp = scriptEntry(nextEntry);
         if (exp[31:24] == 8'hAA) minGap = int'(exp[7:0]) + 1;   // next START must wait
      end else begin
         reportError($sformatf("unexpected %0d-byte bus transaction, ID matched %0d",
                               frame.size(), idMatched));
      end
   endtask

   always @(negedge sda) begin
      if (RESET_N && scl === 1'b1) begin   // START
         if (released) reportError("bus activity after camera release");
         if (minGap > 0 && int'(($time - lastStop) / clkPeriod) < minGap) begin
            reportError($sformatf("idle gap of %0d cycles before entry %0d, needs %0d",
                                  ($time - lastStop) / clkPeriod, nextEntry + 1, minGap));
         end
         minGap = 0;
         frame.delete();
         slot = 0;
         anyNack = 1'b0;
         inFrame = 1'b1;
      end
   end

   always @(posedge sda) begin
      if (RESET_N && scl === 1'b1 && inFrame) begin   // STOP
         inFrame = 1'b0;
         lastStop = $time;
         decodeFrame();
      end
   end

   always @(posedge scl) begin
      if (inFrame) begin
         if (slot < 8) begin
            curByte = {curByte[6:0], sda};
            slot++;
         end else begin
            // master NACK after a read byte is not a slave failure
            if (frame.size() == 0 || frame[0][0] == 1'b0) anyNack = anyNack | sda;
            frame.push_back(curByte);
            slot = 0;
         end
      end
   end

   always @(negedge CLK_400K) begin
      if (RESET_N && cameraReleased && !released) begin
         released = 1'b1;
         if (writesSeen != writeCount) begin
            reportError($sformatf("cameraReleased rose after %0d of %0d writes",
                                  writesSeen, writeCount));
         end
      end else if (RESET_N && !cameraReleased && released) begin
         reportError("cameraReleased fell after release");
      end
   end

   always @(posedge finalCheck) begin
      compareValue("sensorId", sensorId, 8'h88);
      if (badIds != int'(wrongIds)) begin
         reportError($sformatf("saw %0d wrong ID reads, model sent %0d", badIds, wrongIds));
      end
      if (nackedFrames == 0) reportError("no unacknowledged ID transaction was seen");
      if (writesSeen != writeCount) reportError("script write count is off");
      if (!released) reportError("camera was never released");
   end

endmodule

`default_nettype wire

// ==== verification/i2cSensorModel.sv ====
`default_nettype none

module i2cSensorModel (
   inout wire sda,
   input wire logic scl,
   input wire logic [1:0] wrongIds   // wrong ID answers before the real one
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [6:0] ownAddr = 7'h36;   // 0x6C write address

   logic drvLow = 1'b0;
   logic inFrame = 1'b0;
   logic readMode = 1'b0;
   logic ignoreFrame = 1'b0;
   logic nackPending = 1'b1;   // first transaction goes unacknowledged
   int slot = 0;
   int byteIdx = 0;
   int idReads = 0;
   logic [7:0] rxByte = 8'h00;
   logic [7:0] txByte = 8'h00;
   logic [15:0] ptr = 16'h0000;

   assign sda = drvLow ? 1'b0 : 1'bz;

   function automatic logic [7:0] idAnswer();
      logic [7:0] value;
      value = (idReads < int'(wrongIds)) ? 8'h80 + 8'(idReads) : 8'h88;
      if (ptr == 16'h300B) begin
         idReads++;
      end else begin
         value = 8'h00;   // only the ID register is modelled
      end
      return value;
   endfunction

   task automatic handleByte();
      if (readMode && byteIdx == 1) begin
         drvLow = 1'b0;   // master NACK slot
      end else if (byteIdx == 0) begin
         ignoreFrame = (rxByte[7:1] != ownAddr) || nackPending;
         nackPending = 1'b0;
         readMode = rxByte[0] && !ignoreFrame;
         drvLow = !ignoreFrame;
      end else if (!ignoreFrame) begin
         if (byteIdx == 1) ptr[15:8] = rxByte;
         if (byteIdx == 2) ptr[7:0] = rxByte;
         if (byteIdx == 3) $display("sensor write 0x%h = 0x%h", ptr, rxByte);
         drvLow = 1'b1;
      end
   endtask

   always @(negedge sda) begin
      if (scl === 1'b1) begin   // START
         inFrame = 1'b1;
         slot = 0;
         byteIdx = 0;
         readMode = 1'b0;
         drvLow = 1'b0;
      end
   end

   always @(posedge sda) begin
      if (scl === 1'b1) inFrame = 1'b0;   // STOP
   end

   always @(posedge scl) begin
      if (inFrame) begin
         if (slot < 8) rxByte = {rxByte[6:0], sda};
         slot++;
      end
   end

   always @(negedge scl) begin
      #1;
      if (inFrame) begin
         if (slot == 8) begin
            handleByte();
         end else if (slot == 9) begin
            slot = 0;
            byteIdx++;
            drvLow = 1'b0;
            if (readMode && byteIdx == 1) begin
               txByte = idAnswer();
               drvLow = !txByte[7];
            end
         end else if (readMode && byteIdx == 1 && slot >= 1 && slot <= 7) begin
            drvLow = !txByte[7 - slot];   // msb first
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/camConfigTop.sv ====
`default_nettype none

module camConfigTop
   import cameraPkg::*;
(
   input wire logic CLK_400K,
   input wire logic RESET_N,
   output logic i2cScl,
   inout wire i2cSda,
   output logic [7:0] sensorId,
   output logic cameraReleased
);

   logic sclOut;
   logic sdaOut;
   scriptIdxT scriptIdx;
   scriptEntryT entry;

   i2cCmdIf cmdBus ();

   // open-drain sda, pull-up sits on the board
   assign i2cSda = sdaOut ? 1'bz : 1'b0;
   assign i2cScl = sclOut;

   i2cMasterEngine i_engine (
      .CLK_400K (CLK_400K),
      .RESET_N (RESET_N),
      .cmd (cmdBus.engineSide),
      .sclOut (sclOut),
      .sdaOut (sdaOut),
      .sdaIn (i2cSda)
   );

   initScriptRom i_rom (
      .CLK_400K (CLK_400K),
      .idx (scriptIdx),
      .entry (entry)
   );

   cameraInitSequencer i_sequencer (
      .CLK_400K (CLK_400K),
      .RESET_N (RESET_N),
      .cmd (cmdBus.seqSide),
      .scriptIdx (scriptIdx),
      .entry (entry),
      .sensorId (sensorId),
      .cameraReleased (cameraReleased)
   );

endmodule

`default_nettype wire

// ==== src/cameraInitSequencer.sv ====
`default_nettype none

module cameraInitSequencer
   import i2cPkg::*;
   import cameraPkg::*;
(
   input wire logic CLK_400K,
   input wire logic RESET_N,
   i2cCmdIf.seqSide cmd,
   output scriptIdxT scriptIdx,
   input wire scriptEntryT entry,
   output logic [byteW-1:0] sensorId,
   output logic cameraReleased
);

   seqStateE state;
   logic [7:0] waitCnt;   // id gap and delay entries
   logic isDelay;

   assign isDelay = (entry.addr == delayMarker);

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state <= stIdPtr;
         cmd.start <= 1'b0;
         scriptIdx <= '0;
         waitCnt <= 8'd0;
         sensorId <= '0;
         cameraReleased <= 1'b0;
      end else begin
         cmd.start <= 1'b0;
         case (state)
            stIdPtr: begin
               cmd.start <= 1'b1;
               state <= stIdPtrWait;
            end
            stIdPtrWait: begin
               if (cmd.done) begin
                  waitCnt <= 8'd0;
                  state <= cmd.nack ? stIdPtr : stIdGap;
               end
            end
            stIdGap: begin
               waitCnt <= waitCnt + 8'd1;
               if (waitCnt == 8'(idGapLen)) begin
                  state <= stIdRead;
               end
            end
            stIdRead: begin
               cmd.start <= 1'b1;
               state <= stIdReadWait;
            end
            stIdReadWait: begin
               if (cmd.done) begin
                  if (!cmd.nack) begin
                     sensorId <= cmd.rdData;
                  end
                  if (cmd.nack || cmd.rdData != expectedId) begin
                     state <= stIdPtr;   // whole ID check again
                  end else begin
                     scriptIdx <= '0;
                     state <= stFetch;
                  end
               end
            end
            stFetch: begin
               state <= stDecode;   // entry valid next cycle
            end
            stDecode: begin
               if (isDelay) begin
                  waitCnt <= 8'd0;
                  state <= stDelay;
               end else begin
                  cmd.start <= 1'b1;
                  state <= stWriteWait;
               end
            end
            stWriteWait: begin
               if (cmd.done) begin
                  state <= cmd.nack ? stDecode : stNext;   // same entry again on nack
               end
            end
            stDelay: begin
               if (waitCnt == entry.data) begin
                  state <= stNext;
               end else begin
                  waitCnt <= waitCnt + 8'd1;
               end
            end
            stNext: begin
               if (scriptIdx == scriptIdxT'(scriptLen - 1)) begin
                  cameraReleased <= 1'b1;
                  state <= stReleased;
               end else begin
                  scriptIdx <= scriptIdx + 1'b1;
                  state <= stFetch;
               end
            end
            default: begin
               cameraReleased <= 1'b1;
            end
         endcase
      end
   end

   // command fields, loaded with the start strobe and held until done
   always_ff @(posedge CLK_400K) begin
      if (state == stIdPtr) begin
         cmd.op <= opWritePtr;
         cmd.slaveAddr <= sensorAddr;
         cmd.regPtr <= idReg;
      end else if (state == stIdRead) begin
         cmd.op <= opReadByte;
      end else if (state == stDecode && !isDelay) begin
         cmd.op <= opWriteReg;
         cmd.slaveAddr <= entry.addr;
         cmd.regPtr <= entry.ptr;
         cmd.wrData <= entry.data;
      end
   end

   releaseSticky: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      cameraReleased |=> cameraReleased);

endmodule

`default_nettype wire

// ==== src/initScriptRom.sv ====
`default_nettype none

module initScriptRom
   import cameraPkg::*;
(
   input wire logic CLK_400K,
   input wire scriptIdxT idx,
   output scriptEntryT entry   // one cycle after idx
);

   function automatic scriptEntryT wr(input logic [15:0] ptr, input logic [7:0] value);
      scriptEntryT e;
      e.addr = sensorAddr;
      e.ptr = ptr;
      e.data = value;
      return e;
   endfunction

   function automatic scriptEntryT dly(input logic [7:0] cycles);
      scriptEntryT e;
      e.addr = delayMarker;
      e.ptr = 16'h0000;
      e.data = cycles;
      return e;
   endfunction

   always_ff @(posedge CLK_400K) begin
      case (idx)
         4'd0: entry <= wr(16'h0103, 8'h01);    // software reset
         4'd1: entry <= dly(8'd10);
         4'd2: entry <= wr(16'h0100, 8'h00);    // standby
         4'd3: entry <= wr(16'h0302, 8'h18);    // pll multiplier
         4'd4: entry <= wr(16'h0303, 8'h00);
         4'd5: entry <= wr(16'h0304, 8'h03);    // pll mipi divider
         4'd6: entry <= wr(16'h3018, 8'h72);    // four mipi lanes
         4'd7: entry <= wr(16'h3808, 8'h02);    // x size high
         4'd8: entry <= wr(16'h3809, 8'h80);
         4'd9: entry <= wr(16'h380A, 8'h01);    // y size high
         4'd10: entry <= wr(16'h380B, 8'hE0);   // 640x480 output
         4'd11: entry <= dly(8'd10);
         4'd12: entry <= wr(16'h0100, 8'h01);   // streaming
         default: entry <= dly(8'd0);           // past the end, harmless
      endcase
   end

endmodule

`default_nettype wire

// ==== src/i2cMasterEngine.sv ====
`default_nettype none

module i2cMasterEngine
   import i2cPkg::*;
(
   input wire logic CLK_400K,
   input wire logic RESET_N,
   i2cCmdIf.engineSide cmd,
   output logic sclOut,   // 1 releases the line
   output logic sdaOut,   // 1 releases the line
   input wire logic sdaIn
);

   typedef enum logic [2:0] {
      engIdle,
      engStart,
      engBit,
      engStop,
      engDone
   } engStateE;

   engStateE state;
   logic [phaseW-1:0] phase;
   logic [3:0] bitCnt;      // 0..7 data, 8 is the ack slot
   logic [1:0] byteCnt;
   logic [1:0] lastByte;
   logic [byteW-1:0] curByte;
   logic ackSlot;
   logic readSlot;
   logic readStrobe;

   // frame length follows the opcode
   always_comb begin
      case (cmd.op)
         opWritePtr: lastByte = 2'd2;
         opReadByte: lastByte = 2'd1;
         default: lastByte = 2'd3;
      endcase
   end

   always_comb begin
      case (byteCnt)
         2'd0: curByte = (cmd.op == opReadByte) ? {cmd.slaveAddr[byteW-1:1], 1'b1}
                                                : cmd.slaveAddr;
         2'd1: curByte = cmd.regPtr[ptrW-1:byteW];
         2'd2: curByte = cmd.regPtr[byteW-1:0];
         default: curByte = cmd.wrData;
      endcase
   end

   assign ackSlot = (bitCnt == 4'd8);
   assign readSlot = (cmd.op == opReadByte) && (byteCnt == 2'd1);   // second byte comes in
   assign readStrobe = (state == engBit) && (phase == phSample) && readSlot && !ackSlot;

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state <= engIdle;
         phase <= phSetup;
         bitCnt <= 4'd0;
         byteCnt <= 2'd0;
         sclOut <= 1'b1;
         sdaOut <= 1'b1;
         cmd.done <= 1'b0;
         cmd.nack <= 1'b0;
      end else begin
         cmd.done <= 1'b0;
         case (state)
            engIdle: begin
               if (cmd.start) begin
                  state <= engStart;
                  phase <= phSetup;
                  bitCnt <= 4'd0;
                  byteCnt <= 2'd0;
                  cmd.nack <= 1'b0;
               end
            end
            engStart: begin
               phase <= phase + 1'b1;
               if (phase == phSetup) begin
                  sclOut <= 1'b1;
                  sdaOut <= 1'b1;
               end else if (phase == phRise) begin
                  sdaOut <= 1'b0;   // START, sda falls with scl high
               end else if (phase == phFall) begin
                  sclOut <= 1'b0;
                  state <= engBit;
               end
            end
            engBit: begin
               phase <= phase + 1'b1;
               if (phase == phSetup) begin
                  // released for ack slots and for the whole read byte, so the
                  // read byte ends with a NACK from the master
                  sdaOut <= (ackSlot || readSlot) ? 1'b1 : curByte[3'd7 - bitCnt[2:0]];
               end else if (phase == phRise) begin
                  sclOut <= 1'b1;
               end else if (phase == phSample) begin
                  if (ackSlot && !readSlot && sdaIn) begin
                     cmd.nack <= 1'b1;   // slave left sda high
                  end
               end else begin
                  sclOut <= 1'b0;
                  if (ackSlot) begin
                     bitCnt <= 4'd0;
                     if (byteCnt == lastByte) begin
                        state <= engStop;
                     end else begin
                        byteCnt <= byteCnt + 2'd1;
                     end
                  end else begin
                     bitCnt <= bitCnt + 4'd1;
                  end
               end
            end
            engStop: begin
               phase <= phase + 1'b1;
               if (phase == phSetup) begin
                  sdaOut <= 1'b0;
               end else if (phase == phRise) begin
                  sclOut <= 1'b1;
               end else if (phase == phFall) begin
                  sdaOut <= 1'b1;   // STOP, sda rises with scl high
                  state <= engDone;
               end
            end
            default: begin
               cmd.done <= 1'b1;   // one cycle after STOP
               state <= engIdle;
            end
         endcase
      end
   end

   always_ff @(posedge CLK_400K) begin
      if (readStrobe) begin
         cmd.rdData <= {cmd.rdData[byteW-2:0], sdaIn};   // msb first
      end
   end

   // the sequencer waits for done before the next command
   startWhileBusy: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      cmd.start |-> state == engIdle);

endmodule

`default_nettype wire

// ==== src/i2cCmdIf.sv ====
`default_nettype none

interface i2cCmdIf
   import i2cPkg::*;
();

   logic start;                  // one cycle pulse
   i2cOpE op;
   logic [byteW-1:0] slaveAddr;  // 8-bit write address
   logic [ptrW-1:0] regPtr;
   logic [byteW-1:0] wrData;

   logic done;                   // one cycle pulse
   logic [byteW-1:0] rdData;     // valid from done until the next start
   logic nack;                   // valid with done

   modport seqSide (
      output start,
      output op,
      output slaveAddr,
      output regPtr,
      output wrData,
      input done,
      input rdData,
      input nack
   );

   modport engineSide (
      input start,
      input op,
      input slaveAddr,
      input regPtr,
      input wrData,
      output done,
      output rdData,
      output nack
   );

endinterface

`default_nettype wire

// ==== src/cameraPkg.sv ====
`default_nettype none

package cameraPkg;

   localparam logic [7:0] sensorAddr = 8'h6C;  // write address, read bit added by the engine
   localparam logic [15:0] idReg = 16'h300B;
   localparam logic [7:0] expectedId = 8'h88;

   // gap between pointer write and ID read
   localparam int idGapLen = 3;

   // addr field value that turns an entry into a wait
   localparam logic [7:0] delayMarker = 8'hAA;

   typedef struct packed {
      logic [7:0] addr;   // slave address or delayMarker
      logic [15:0] ptr;   // register pointer
      logic [7:0] data;   // register value, or wait length for a delay entry
   } scriptEntryT;

   localparam int scriptLen = 13;

   typedef logic [3:0] scriptIdxT;

   typedef enum logic [3:0] {
      stIdPtr,       // issue pointer write to the ID register
      stIdPtrWait,
      stIdGap,
      stIdRead,      // issue one byte read
      stIdReadWait,
      stFetch,       // ROM lookup in flight
      stDecode,
      stWriteWait,
      stDelay,
      stNext,
      stReleased
   } seqStateE;

endpackage

`default_nettype wire

// ==== src/i2cPkg.sv ====
`default_nettype none

package i2cPkg;

   // one command per start strobe
   typedef enum logic [1:0] {
      opWritePtr = 2'd0, // address, pointer high, pointer low
      opReadByte = 2'd1, // address with read bit, one byte in, NACK
      opWriteReg = 2'd2  // address, pointer high, pointer low, data
   } i2cOpE;

   localparam int byteW = 8;
   localparam int ptrW = 16;

   // four clock cycles per SCL bit, 400 kHz in gives 100 kHz on the bus
   localparam int phasesPerBit = 4;
   localparam int phaseW = $clog2(phasesPerBit);

   // quarters of one bit slot
   localparam logic [phaseW-1:0] phSetup = phaseW'(0);                 // scl low, sda moves
   localparam logic [phaseW-1:0] phRise = phaseW'(1);                  // scl released
   localparam logic [phaseW-1:0] phSample = phaseW'(2);                // scl high, sda sampled
   localparam logic [phaseW-1:0] phFall = phaseW'(phasesPerBit - 1);   // scl pulled low

endpackage

`default_nettype wire
